//--- filelist.f
logic/ppu_pkg.sv
logic/scan_timer.sv
logic/oam_axi_slave.sv
logic/sprite_eval_fsm.sv
logic/sp_pixel.sv
logic/sprite_unit_top.sv
verification/sprite_unit_tb.sv

//--- logic/oam_axi_slave.sv
`timescale 1ns/1ns

module oam_axi_slave (
    input  logic               clk,
    input  logic               arst_n,
    input  ppu_pkg::axil_req_t axil_req,
    output ppu_pkg::axil_rsp_t axil_rsp,
    input  logic [5:0]         oam_idx,
    output ppu_pkg::oam_word_u oam_word,
    input  logic [6:0]         pat_idx,
    output logic [15:0]        pat_word,
    input  logic               overflow_set
);
    import ppu_pkg::*;

    oam_word_u   oam_mem [NUM_OAM];
    logic [15:0] pat_mem [NUM_TILES * SPRITE_WIDTH];
    logic        ovf_flag;

    logic wr_fire;
    logic rd_fire;
    logic wr_oam, wr_pat, wr_st;
    logic rd_oam, rd_pat, rd_st;

    function automatic logic hit_oam(input logic [11:0] addr);
        return addr[11:8] == OAM_BASE[11:8];
    endfunction

    function automatic logic hit_pat(input logic [11:0] addr);
        return addr[11:9] == PAT_BASE[11:9];
    endfunction

    function automatic logic hit_status(input logic [11:0] addr);
        return addr[11:2] == STATUS_ADDR[11:2];
    endfunction

    assign wr_oam = hit_oam(axil_req.awaddr);
    assign wr_pat = hit_pat(axil_req.awaddr);
    assign wr_st = hit_status(axil_req.awaddr);
    assign rd_oam = hit_oam(axil_req.araddr);
    assign rd_pat = hit_pat(axil_req.araddr);
    assign rd_st = hit_status(axil_req.araddr);

    // ready is a one-cycle pulse, so valid is still up at the edge
    assign wr_fire = axil_rsp.awready && axil_req.awvalid && axil_req.wvalid;
    assign rd_fire = axil_rsp.arready && axil_req.arvalid;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            axil_rsp <= '0;
            ovf_flag <= 1'b0;
        end else begin
            // write channel, both address and data needed
            axil_rsp.awready <= axil_req.awvalid && axil_req.wvalid
                                && !axil_rsp.bvalid && !axil_rsp.awready;
            axil_rsp.wready <= axil_req.awvalid && axil_req.wvalid
                               && !axil_rsp.bvalid && !axil_rsp.awready;
            if (wr_fire) begin
                axil_rsp.bvalid <= 1'b1;
                axil_rsp.bresp <= (wr_oam || wr_pat || wr_st) ? RESP_OKAY : RESP_SLVERR;
            end else if (axil_req.bready) begin
                axil_rsp.bvalid <= 1'b0;
            end

            axil_rsp.arready <= axil_req.arvalid && !axil_rsp.rvalid && !axil_rsp.arready;
            if (rd_fire) begin
                axil_rsp.rvalid <= 1'b1;
                axil_rsp.rresp <= RESP_OKAY;
                if (rd_oam) begin
                    axil_rsp.rdata <= oam_mem[axil_req.araddr[7:2]].raw;
                end else if (rd_pat) begin
                    axil_rsp.rdata <= {16'd0, pat_mem[axil_req.araddr[8:2]]};
                end else if (rd_st) begin
                    axil_rsp.rdata <= {31'd0, ovf_flag};
                end else begin
                    axil_rsp.rdata <= 32'd0;
                    axil_rsp.rresp <= RESP_SLVERR;
                end
            end else if (axil_req.rready) begin
                axil_rsp.rvalid <= 1'b0;
            end

            // sticky, any write to status clears it; a new overflow wins
            if (overflow_set) begin
                ovf_flag <= 1'b1;
            end else if (wr_fire && wr_st) begin
                ovf_flag <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire && wr_oam) begin
            oam_mem[axil_req.awaddr[7:2]].raw <= axil_req.wdata;
        end
        if (wr_fire && wr_pat) begin
            pat_mem[axil_req.awaddr[8:2]] <= axil_req.wdata[15:0];  // lo plane in low byte
        end
    end

    assign oam_word = oam_mem[oam_idx];
    assign pat_word = pat_mem[pat_idx];

endmodule

//--- logic/ppu_pkg.sv
package ppu_pkg;

    // sprite geometry and memory sizes
    localparam int SPRITE_WIDTH = 8;
    localparam int NUM_OAM = 64;
    localparam int NUM_SEC = 8;
    localparam int NUM_TILES = 16;

    // raster timing, in pixel clocks
    localparam int COLS_PER_LINE = 341;
    localparam int LINES_PER_FRAME = 262;
    localparam int VISIBLE_COLS = 256;
    localparam int VISIBLE_ROWS = 240;
    localparam int CLK_DIV = 4;      // master clocks per pixel

    // host address map, byte addresses
    localparam logic [11:0] OAM_BASE = 12'h000;
    localparam logic [11:0] PAT_BASE = 12'h400;
    localparam logic [11:0] STATUS_ADDR = 12'h800;

    localparam logic [1:0] RESP_OKAY = 2'd0;
    localparam logic [1:0] RESP_SLVERR = 2'd2;

    typedef struct packed {
        logic [7:0] y_pos;
        logic [7:0] tile;
        logic [7:0] attribute;  // 7 vflip, 6 hflip, 5 prio, 1:0 palette
        logic [7:0] x_pos;
    } oam_entry_t;

    // host sees a plain word, evaluator sees the fields
    typedef union packed {
        logic [31:0] raw;
        oam_entry_t  entry;
    } oam_word_u;

    typedef struct packed {
        logic       active;
        logic [8:0] x_pos;
        logic [7:0] attribute;
        logic [7:0] bitmap_hi;
        logic [7:0] bitmap_lo;
    } second_oam_t;

    typedef struct packed {
        logic        awvalid;
        logic [11:0] awaddr;
        logic        wvalid;
        logic [31:0] wdata;
        logic        bready;
        logic        arvalid;
        logic [11:0] araddr;
        logic        rready;
    } axil_req_t;

    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        logic [1:0]  bresp;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axil_rsp_t;

endpackage

//--- logic/scan_timer.sv
`timescale 1ns/1ns

module scan_timer (
    input  logic       clk,
    input  logic       arst_n,
    output logic       clk_en,
    output logic [8:0] row,
    output logic [8:0] col,
    output logic       eval_start
);
    import ppu_pkg::*;

    logic [1:0] div_cnt;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            div_cnt <= 2'd0;
        end else begin
            div_cnt <= div_cnt + 2'd1;  // wraps every CLK_DIV clocks
        end
    end

    assign clk_en = (div_cnt == 2'(CLK_DIV - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            col <= 9'd0;
            row <= 9'd0;
        end else if (clk_en) begin
            if (col == 9'(COLS_PER_LINE - 1)) begin
                col <= 9'd0;
                if (row == 9'(LINES_PER_FRAME - 1)) begin
                    row <= 9'd0;
                end else begin
                    row <= row + 9'd1;
                end
            end else begin
                col <= col + 9'd1;
            end
        end
    end

    // col steps onto the first hidden column at this edge
    assign eval_start = clk_en && (col == 9'(VISIBLE_COLS - 1));

endmodule

//--- logic/sp_pixel.sv
`timescale 1ns/1ns

module sp_pixel (
    input  logic                 clk,     // master clock
    input  logic                 clk_en,  // pixel tick, master clock / 4
    input  logic                 arst_n,
    input  logic [8:0]           row,
    input  logic [8:0]           col,
    input  ppu_pkg::second_oam_t sec_oam [ppu_pkg::NUM_SEC],
    output logic [3:0]           sp_color_idx,  // palette above color bits
    output logic                 sp_prio
);
    import ppu_pkg::*;

    second_oam_t curr_sp;
    logic        sp_hit;
    logic [8:0]  curr_off;
    logic        visible;
    logic [8:0]  offset [NUM_SEC];
    logic [NUM_SEC-1:0] covers;

    assign visible = (col < 9'(VISIBLE_COLS)) && (row < 9'(VISIBLE_ROWS));

    always_comb begin
        for (int i = 0; i < NUM_SEC; i++) begin
            offset[i] = col - sec_oam[i].x_pos;
            covers[i] = sec_oam[i].active && (sec_oam[i].x_pos <= col)
                        && (offset[i] < 9'(SPRITE_WIDTH));
        end
    end

    // lowest slot index wins
    always_comb begin
        curr_sp = '0;
        curr_off = 9'd0;
        sp_hit = 1'b0;
        for (int i = NUM_SEC - 1; i >= 0; i--) begin
            if (covers[i]) begin
                curr_sp = sec_oam[i];
                curr_off = offset[i];
                sp_hit = 1'b1;
            end
        end
    end

    logic [2:0] bit_idx;
    logic [1:0] color_bits;

    always_comb begin
        if (curr_sp.attribute[6]) begin
            bit_idx = curr_off[2:0];          // mirrored
        end else begin
            bit_idx = 3'd7 - curr_off[2:0];   // msb is leftmost pixel
        end
        color_bits = {curr_sp.bitmap_hi[bit_idx], curr_sp.bitmap_lo[bit_idx]};
    end

    always_comb begin
        sp_color_idx = 4'd0;
        sp_prio = 1'b0;
        if (sp_hit && visible) begin
            sp_color_idx = {curr_sp.attribute[1:0], color_bits};
            sp_prio = curr_sp.attribute[5];
        end
    end

endmodule

//--- logic/sprite_eval_fsm.sv
`timescale 1ns/1ns

module sprite_eval_fsm (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 clk_en,
    input  logic                 eval_start,
    input  logic [8:0]           row,
    output logic [5:0]           oam_idx,
    input  ppu_pkg::oam_word_u   oam_word,
    output logic [6:0]           pat_idx,
    input  logic [15:0]          pat_word,
    output ppu_pkg::second_oam_t sec_oam [ppu_pkg::NUM_SEC],
    output logic                 overflow_set
);
    import ppu_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_SCAN,
        S_FETCH,
        S_DONE
    } state_t;

    state_t     state;
    logic [8:0] target_row;   // row being prepared
    logic [5:0] scan_idx;
    logic [3:0] found_cnt;
    logic [2:0] fetch_idx;
    logic       ovf_seen;

    logic [3:0] tile_q [NUM_SEC];
    logic [2:0] line_q [NUM_SEC];

    oam_entry_t entry;
    logic [8:0] row_diff;
    logic       in_range;
    logic       take;
    logic [2:0] fetch_line;

    assign entry = oam_word.entry;
    assign row_diff = target_row - {1'b0, entry.y_pos};  // negative wraps high
    assign in_range = (row_diff < 9'(SPRITE_WIDTH));
    assign take = in_range && (found_cnt < 4'(NUM_SEC));
    assign oam_idx = scan_idx;

    // vertical flip reads the rows bottom up
    assign fetch_line = sec_oam[fetch_idx].attribute[7] ? ~line_q[fetch_idx]
                                                        : line_q[fetch_idx];
    assign pat_idx = {tile_q[fetch_idx], fetch_line};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= S_IDLE;
            target_row <= 9'd0;
            scan_idx <= 6'd0;
            found_cnt <= 4'd0;
            fetch_idx <= 3'd0;
            ovf_seen <= 1'b0;
            overflow_set <= 1'b0;
            for (int i = 0; i < NUM_SEC; i++) begin
                sec_oam[i] <= '0;
            end
        end else begin
            overflow_set <= 1'b0;
            if (clk_en) begin
                if (eval_start) begin
                    state <= S_SCAN;
                    target_row <= (row == 9'(LINES_PER_FRAME - 1)) ? 9'd0 : row + 9'd1;
                    scan_idx <= 6'd0;
                    found_cnt <= 4'd0;
                    fetch_idx <= 3'd0;
                    ovf_seen <= 1'b0;
                    for (int i = 0; i < NUM_SEC; i++) begin
                        sec_oam[i] <= '0;
                    end
                end else begin
                    case (state)
                        S_SCAN: begin
                            if (take) begin
                                sec_oam[found_cnt[2:0]].x_pos <= {1'b0, entry.x_pos};
                                sec_oam[found_cnt[2:0]].attribute <= entry.attribute;
                                found_cnt <= found_cnt + 4'd1;
                            end else if (in_range && !ovf_seen) begin
                                overflow_set <= 1'b1;  // ninth sprite, dropped
                                ovf_seen <= 1'b1;
                            end
                            scan_idx <= scan_idx + 6'd1;
                            if (scan_idx == 6'(NUM_OAM - 1)) begin
                                state <= (found_cnt == 4'd0 && !take) ? S_DONE : S_FETCH;
                            end
                        end
                        S_FETCH: begin
                            sec_oam[fetch_idx].bitmap_lo <= pat_word[7:0];
                            sec_oam[fetch_idx].bitmap_hi <= pat_word[15:8];
                            sec_oam[fetch_idx].active <= 1'b1;
                            fetch_idx <= fetch_idx + 3'd1;
                            if ({1'b0, fetch_idx} == found_cnt - 4'd1) begin
                                state <= S_DONE;
                            end
                        end
                        S_DONE: begin
                            state <= S_IDLE;
                        end
                        default: begin
                            state <= S_IDLE;
                        end
                    endcase
                end
            end
        end
    end

    // tile and line of each found sprite, kept for the fetch phase
    always_ff @(posedge clk) begin
        if (clk_en && !eval_start && state == S_SCAN && take) begin
            tile_q[found_cnt[2:0]] <= entry.tile[3:0];
            line_q[found_cnt[2:0]] <= row_diff[2:0];
        end
    end

endmodule

//--- logic/sprite_unit_top.sv
`timescale 1ns/1ns

module sprite_unit_top (
    input  logic               clk,
    input  logic               arst_n,
    input  ppu_pkg::axil_req_t axil_req,
    output ppu_pkg::axil_rsp_t axil_rsp,
    output logic [8:0]         row,
    output logic [8:0]         col,
    output logic [3:0]         sp_color_idx,
    output logic               sp_prio
);
    import ppu_pkg::*;

    logic        clk_en;
    logic        eval_start;
    logic [5:0]  oam_idx;
    oam_word_u   oam_word;
    logic [6:0]  pat_idx;
    logic [15:0] pat_word;
    logic        overflow_set;
    second_oam_t sec_oam [NUM_SEC];

    scan_timer u_timer (
        .clk        (clk),
        .arst_n     (arst_n),
        .clk_en     (clk_en),
        .row        (row),
        .col        (col),
        .eval_start (eval_start)
    );

    oam_axi_slave u_slave (
        .clk          (clk),
        .arst_n       (arst_n),
        .axil_req     (axil_req),
        .axil_rsp     (axil_rsp),
        .oam_idx      (oam_idx),
        .oam_word     (oam_word),
        .pat_idx      (pat_idx),
        .pat_word     (pat_word),
        .overflow_set (overflow_set)
    );

    sprite_eval_fsm u_eval (
        .clk          (clk),
        .arst_n       (arst_n),
        .clk_en       (clk_en),
        .eval_start   (eval_start),
        .row          (row),
        .oam_idx      (oam_idx),
        .oam_word     (oam_word),
        .pat_idx      (pat_idx),
        .pat_word     (pat_word),
        .sec_oam      (sec_oam),
        .overflow_set (overflow_set)
    );

    sp_pixel u_pixel (
        .clk          (clk),
        .clk_en       (clk_en),
        .arst_n       (arst_n),
        .row          (row),
        .col          (col),
        .sec_oam      (sec_oam),
        .sp_color_idx (sp_color_idx),
        .sp_prio      (sp_prio)
    );

endmodule

//--- run_sim.sh
#!/bin/sh
# build the sprite unit testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module sprite_unit_tb -f filelist.f -o sprite_sim \
    && ./obj_dir/sprite_sim | tee /dev/stderr | grep -qx "PASS: all tests" \
    && echo "run_sim: simulation passed" \
    || { echo "run_sim: simulation failed" >&2; exit 1; }

//--- verification/sprite_unit_tb.sv
`timescale 1ns/1ns

module sprite_unit_tb;
    import ppu_pkg::*;

    localparam int FRAME_CLKS = COLS_PER_LINE * LINES_PER_FRAME * CLK_DIV;
    localparam int AXI_LIMIT = 64;   // clocks per handshake phase

    logic       clk;
    logic       arst_n;
    axil_req_t  req;
    axil_rsp_t  rsp;
    logic [8:0] row;
    logic [8:0] col;
    logic [3:0] sp_color_idx;
    logic       sp_prio;

    oam_entry_t  oam_model [NUM_OAM];  // what the host wrote
    logic [15:0] pat_model [NUM_TILES * SPRITE_WIDTH];

    integer seed;
    string  test_name;
    int     test_err;
    int     total_err;
    int     tests_run;
    int     tests_failed;
    bit     stuck;  // set by any timeout so later waits fall through

    sprite_unit_top DUT (
        .clk          (clk),
        .arst_n       (arst_n),
        .axil_req     (req),
        .axil_rsp     (rsp),
        .row          (row),
        .col          (col),
        .sp_color_idx (sp_color_idx),
        .sp_prio      (sp_prio)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // {prio, palette, hi bit, lo bit} from the host-side tables
    function automatic logic [4:0] expected_pixel(input int r, input int c);
        oam_entry_t  e;
        logic [15:0] pw;
        logic [2:0]  line;
        logic [2:0]  bit_pos;
        logic [4:0]  px;
        int          d;
        int          off;
        int          found;
        bit          done;
        px = 5'd0;
        found = 0;
        done = 1'b0;
        if (r < VISIBLE_ROWS && c < VISIBLE_COLS) begin
            for (int i = 0; i < NUM_OAM; i++) begin
                e = oam_model[6'(i)];
                d = r - int'(e.y_pos);
                off = c - int'(e.x_pos);
                if (!done && d >= 0 && d < SPRITE_WIDTH && found < NUM_SEC) begin
                    found++;  // only eight per row make it
                    if (off >= 0 && off < SPRITE_WIDTH) begin
                        line = e.attribute[7] ? 3'(7 - d) : 3'(d);
                        pw = pat_model[{e.tile[3:0], line}];
                        bit_pos = e.attribute[6] ? 3'(off) : 3'(7 - off);
                        px = {e.attribute[5], e.attribute[1:0], pw[{1'b1, bit_pos}],
                              pw[{1'b0, bit_pos}]};
                        done = 1'b1;
                    end
                end
            end
        end
        return px;
    endfunction

    task automatic report_timeout(input string what);
        $display("timeout: %s", what);
        test_err++;
        stuck = 1'b1;
    endtask

    task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp) else begin
            $display("Error %s: %s expected %h, actual %h", test_name, what, exp, got);
            test_err++;
        end
    endtask

    task automatic axi_write(input logic [11:0] addr, input logic [31:0] data, input int hold,
                             output logic [1:0] resp);
        int cycles;
        resp = 2'd3;
        if (!stuck) begin
            @(negedge clk);
            req.awvalid = 1'b1;
            req.awaddr = addr;
            req.wvalid = 1'b1;
            req.wdata = data;
            req.bready = (hold == 0);
            cycles = 0;
            while (!rsp.awready && cycles < AXI_LIMIT) begin
                @(negedge clk);
                cycles++;
            end
            if (cycles == AXI_LIMIT) begin
                report_timeout($sformatf("write to %h never accepted", addr));
            end else begin
                assert (rsp.wready) else begin
                    $display("wready stayed low while awready was high for %h", addr);
                    test_err++;
                end
                @(negedge clk);  // accepted on the edge just passed
                req.awvalid = 1'b0;
                req.wvalid = 1'b0;
                cycles = 0;
                while (!rsp.bvalid && cycles < AXI_LIMIT) begin
                    @(negedge clk);
                    cycles++;
                end
                if (cycles == AXI_LIMIT) begin
                    report_timeout($sformatf("no write response from %h", addr));
                end
                resp = rsp.bresp;
                for (int i = 0; i < hold; i++) begin
                    @(negedge clk);
                    assert (rsp.bvalid && rsp.bresp == resp) else begin
                        $display("write response from %h dropped while bready was low", addr);
                        test_err++;
                    end
                end
            end
            req.awvalid = 1'b0;
            req.wvalid = 1'b0;
            req.bready = 1'b1;
        end
    endtask

    task automatic axi_read(input logic [11:0] addr, input int hold,
                            output logic [31:0] data, output logic [1:0] resp);
        int cycles;
        data = '0;
        resp = 2'd3;
        if (!stuck) begin
            @(negedge clk);
            req.arvalid = 1'b1;
            req.araddr = addr;
            req.rready = (hold == 0);
            cycles = 0;
            while (!rsp.arready && cycles < AXI_LIMIT) begin
                @(negedge clk);
                cycles++;
            end
            if (cycles == AXI_LIMIT) begin
                report_timeout($sformatf("read of %h never accepted", addr));
            end else begin
                @(negedge clk);
                req.arvalid = 1'b0;
                cycles = 0;
                while (!rsp.rvalid && cycles < AXI_LIMIT) begin
                    @(negedge clk);
                    cycles++;
                end
                if (cycles == AXI_LIMIT) begin
                    report_timeout($sformatf("no read data from %h", addr));
                end
                data = rsp.rdata;
                resp = rsp.rresp;
                for (int i = 0; i < hold; i++) begin
                    @(negedge clk);
                    assert (rsp.rvalid && rsp.rdata == data && rsp.rresp == resp) else begin
                        $display("read data from %h was not held while rready was low", addr);
                        test_err++;
                    end
                end
            end
            req.arvalid = 1'b0;
            req.rready = 1'b1;
        end
    endtask

    task automatic write_oam(input int i, input oam_entry_t e);
        logic [1:0] resp;
        axi_write(12'(OAM_BASE + i * 4), e, 0, resp);
        check_val("oam bresp", 32'(RESP_OKAY), 32'(resp));
        oam_model[6'(i)] = e;
    endtask

    task automatic write_pat(input int i, input logic [15:0] w);
        logic [1:0] resp;
        axi_write(12'(PAT_BASE + i * 4), {16'd0, w}, 0, resp);
        check_val("pattern bresp", 32'(RESP_OKAY), 32'(resp));
        pat_model[7'(i)] = w;
    endtask

    // eight per group, all below the checked rows
    task automatic park_sprite(input int i);
        write_oam(i, {8'(192 + 8 * (i / 8)), 8'(i), 8'h00, 8'(i * 3)});
    endtask

    task automatic wait_pos(input int r, input int c);
        int cycles;
        cycles = 0;
        while (!stuck && !(int'(row) == r && int'(col) == c)) begin
            if (cycles == 2 * FRAME_CLKS) begin
                report_timeout($sformatf("scan never reached row %0d col %0d", r, c));
            end else begin
                @(negedge clk);
                cycles++;
            end
        end
    endtask

    task automatic check_frame(input int last_row);
        int         cycles;
        int         limit;
        int         prev_r;
        int         prev_c;
        int         exp_r;
        int         exp_c;
        int         steps;  // clocks since the last position change
        int         moves;
        logic [4:0] exp_px;
        logic [4:0] got_px;
        wait_pos(LINES_PER_FRAME - 1, 0);  // row 0 evaluated after this
        wait_pos(0, 0);
        limit = (last_row + 2) * COLS_PER_LINE * CLK_DIV;
        prev_r = -1;
        prev_c = -1;
        steps = 0;
        moves = 0;
        cycles = 0;
        while (!stuck && int'(row) <= last_row) begin
            if (int'(row) != prev_r || int'(col) != prev_c) begin
                if (prev_r >= 0) begin
                    exp_c = (prev_c == COLS_PER_LINE - 1) ? 0 : prev_c + 1;
                    exp_r = (prev_c == COLS_PER_LINE - 1) ? prev_r + 1 : prev_r;
                    assert (int'(row) == exp_r && int'(col) == exp_c) else begin
                        $display("Error %s: position expected %0d/%0d, actual %0d/%0d",
                                 test_name, exp_r, exp_c, row, col);
                        test_err++;
                    end
                    if (moves > 0) begin
                        assert (steps == CLK_DIV) else begin
                            $display("Error %s: clocks per pixel expected %0d, actual %0d",
                                     test_name, CLK_DIV, steps);
                            test_err++;
                        end
                    end
                    moves++;
                end
                exp_px = expected_pixel(int'(row), int'(col));
                got_px = {sp_prio, sp_color_idx};
                assert (got_px === exp_px) else begin
                    $display("Error %s: pixel row %0d col %0d expected %h, actual %h",
                             test_name, row, col, exp_px, got_px);
                    test_err++;
                end
                prev_r = int'(row);
                prev_c = int'(col);
                steps = 0;
            end
            if (cycles == limit) begin
                report_timeout("scan did not get past the checked rows");
            end else begin
                @(negedge clk);
                cycles++;
                steps++;
            end
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_err = 0;
    endtask

    task automatic finish_test();
        tests_run++;
        total_err += test_err;
        if (test_err == 0) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, test_err);
        end
    endtask

    initial begin
        oam_entry_t  e;
        logic [31:0] word;
        logic [31:0] rdata;
        logic [1:0]  resp;
        int          idx;
        int          x;
        int          y;
        seed = 1033;
        test_name = "reset";
        test_err = 0;
        total_err = 0;
        tests_run = 0;
        tests_failed = 0;
        stuck = 1'b0;
        arst_n = 1'b0;
        req = '0;
        req.bready = 1'b1;
        req.rready = 1'b1;
        repeat (16) @(negedge clk);
        arst_n = 1'b1;

        start_test("axi_access");
        for (int i = 0; i < 6; i++) begin
            idx = $unsigned($random(seed)) % NUM_OAM;
            word = $random(seed);
            write_oam(idx, word);
            axi_read(12'(OAM_BASE + idx * 4), 0, rdata, resp);
            check_val("oam readback", word, rdata);
            check_val("oam rresp", 32'(RESP_OKAY), 32'(resp));
            idx = $unsigned($random(seed)) % (NUM_TILES * SPRITE_WIDTH);
            word = $random(seed);
            write_pat(idx, word[15:0]);
            axi_read(12'(PAT_BASE + idx * 4), 0, rdata, resp);
            check_val("pattern readback", {16'd0, word[15:0]}, rdata);
            check_val("pattern rresp", 32'(RESP_OKAY), 32'(resp));
        end
        axi_write(12'hC00, 32'hDEAD_BEEF, 6, resp);
        check_val("unmapped bresp", 32'(RESP_SLVERR), 32'(resp));
        axi_read(12'hC04, 6, rdata, resp);
        check_val("unmapped rresp", 32'(RESP_SLVERR), 32'(resp));
        for (int i = 0; i < NUM_TILES * SPRITE_WIDTH; i++) begin
            word = $random(seed);
            write_pat(i, word[15:0]);
        end
        for (int i = 0; i < NUM_OAM; i++) begin
            park_sprite(i);
        end
        finish_test();

        start_test("placement");
        y = 16 + $unsigned($random(seed)) % 128;
        x = $unsigned($random(seed)) % 249;
        e = {8'(y), 8'($random(seed)), 8'($random(seed)) & 8'h23, 8'(x)};
        write_oam(0, e);
        check_frame(y + 9);
        finish_test();

        start_test("flips");
        for (int f = 1; f < 4; f++) begin
            e.attribute = (e.attribute & 8'h3F) | 8'(f << 6);  // h, v, then both
            write_oam(0, e);
            check_frame(y + 9);
        end
        finish_test();

        start_test("overlap");
        y = 16 + $unsigned($random(seed)) % 128;
        x = $unsigned($random(seed)) % 240;
        write_oam(0, {8'(y), 8'($random(seed)), 8'h21, 8'(x)});
        write_oam(1, {8'(y + 2), 8'($random(seed)), 8'h02, 8'(x + 3)});
        check_frame(y + 11);
        finish_test();

        start_test("overflow");
        y = 16 + $unsigned($random(seed)) % 128;
        axi_write(STATUS_ADDR, 32'd0, 0, resp);
        axi_read(STATUS_ADDR, 0, rdata, resp);
        check_val("status before", 32'd0, rdata);
        for (int i = 0; i < 9; i++) begin
            write_oam(i, {8'(y), 8'($random(seed)), 8'($random(seed)) & 8'h23, 8'(4 + 24 * i)});
        end
        check_frame(y + 9);
        axi_read(STATUS_ADDR, 0, rdata, resp);
        check_val("status after nine", 32'd1, rdata);
        park_sprite(8);
        axi_write(STATUS_ADDR, 32'hFFFF_FFFF, 0, resp);
        check_val("status bresp", 32'(RESP_OKAY), 32'(resp));
        axi_read(STATUS_ADDR, 0, rdata, resp);
        check_val("status cleared", 32'd0, rdata);
        check_frame(y + 9);
        axi_read(STATUS_ADDR, 0, rdata, resp);
        check_val("status after eight", 32'd0, rdata);
        finish_test();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_err);
        if (total_err == 0 && !stuck) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
